// ==== source/mmu_consts.svh ====
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// tlb geometry
`define TLB_INDEX_BITS 5
`define TLB_ENTRIES 32

// address widths
`define VADDR_BITS 32
`define PADDR_BITS 32
`define VPPN_BITS 19
`define PPN_BITS 20
`define ASID_BITS 10

// every entry maps a 4 KB even/odd pair
`define PAGE_OFFSET_BITS 12

// pipeline instruction types routed to the MMU
`define INST_TYPE_MMU 11
`define INST_TYPE_PRIV_MMU 10

`endif

// ==== source/mmuPkg.sv ====
`default_nettype none
`include "mmu_consts.svh"

package mmuPkg;

    typedef enum logic [4:0] {TLBSRCH = 5'd1, TLBRD = 5'd2, TLBWR = 5'd3,
                              TLBFILL = 5'd4, INVTLB = 5'd5} tlbOp_e;

    typedef enum logic [1:0] {FETCH = 2'd0, LOAD = 2'd1, STORE = 2'd2} memOp_e;

    typedef enum logic [5:0] {NONE = 6'h00, PIL = 6'h01, PIS = 6'h02, PIF = 6'h03,
                              PME = 6'h04, PPI = 6'h07, TLBR = 6'h3F} excCode_e;

    // op 1 behaves like op 0
    typedef enum logic [4:0] {INV_ALL = 5'd0, INV_ALL_ALT = 5'd1, INV_GLOBAL = 5'd2,
                              INV_PRIVATE = 5'd3} invOp_e;

    typedef struct packed {
        logic [1:0] datm;
        logic [1:0] datf;
        logic pg;
        logic da;
        logic ie;
        logic [1:0] plv;
    } crmd_t;

    typedef struct packed {
        logic [`PPN_BITS-1:0] ppn;
        logic [1:0] plv;
        logic [1:0] mat;
        logic d;
        logic v;
    } pageLo_t;

    typedef struct packed {
        logic e;
        logic g;
        logic [`ASID_BITS-1:0] asid;
        logic [`VPPN_BITS-1:0] vppn;
        pageLo_t lo0; // even page
        pageLo_t lo1; // odd page
    } tlbEntry_t;

    typedef struct packed {
        logic en;
        logic [`TLB_INDEX_BITS-1:0] index;
        tlbEntry_t entry;
    } tlbWrite_t;

    typedef struct packed {
        logic en;
        invOp_e op;
    } tlbInvalidate_t;

    typedef struct packed {
        logic hit;
        logic [`TLB_INDEX_BITS-1:0] index;
    } tlbSearch_t;

    typedef struct packed {
        logic hit;
        pageLo_t page;
    } tlbLookup_t;

    typedef struct packed {
        logic valid;
        memOp_e op;
        logic [`VADDR_BITS-1:0] vaddr;
    } xlateReq_t;

    typedef struct packed {
        logic valid;
        logic [8:0] subcode;
        excCode_e code;
    } excpArg_t;

    typedef struct packed {
        logic paddrValid;
        logic [`PADDR_BITS-1:0] paddr;
        excpArg_t excp;
        logic [1:0] memType;
    } xlateResp_t;

endpackage

`default_nettype wire

// ==== source/tlbMaintenance.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mmu_consts.svh"

module tlbMaintenance (
    input wire logic clk,
    input wire logic reset,
    input wire logic [3:0] instType,
    input wire mmuPkg::tlbOp_e tlbOp,
    input wire mmuPkg::invOp_e invOp,
    input wire logic [31:0] tlbIdxIn,
    input wire logic [31:0] tlbEhiIn,
    input wire logic [31:0] tlbElo0In,
    input wire logic [31:0] tlbElo1In,
    input wire logic [`ASID_BITS-1:0] asid,
    input wire logic stallW,
    input wire logic flushW,
    input wire mmuPkg::tlbSearch_t search,
    output logic [`VPPN_BITS-1:0] searchVppn,
    output mmuPkg::tlbWrite_t write,
    output mmuPkg::tlbInvalidate_t invalidate,
    output logic [31:0] tlbIdxOut
);
    import mmuPkg::*;

    logic mmuInst;
    logic commit;
    logic [31:0] tlbIdxNext;

    // ppn from bit 8 up with G at bit 6 and mat, plv, d and v below it
    function automatic pageLo_t eloToPage(input logic [31:0] elo);
        pageLo_t page;
        page.ppn = elo[`PPN_BITS+7:8];
        page.plv = elo[3:2];
        page.mat = elo[5:4];
        page.d = elo[1];
        page.v = elo[0];
        return page;
    endfunction

    assign mmuInst = (instType == 4'(`INST_TYPE_MMU)) || (instType == 4'(`INST_TYPE_PRIV_MMU));
    assign commit = mmuInst && !stallW && !flushW;
    assign searchVppn = tlbEhiIn[`VADDR_BITS-1:`VADDR_BITS-`VPPN_BITS];

    always_comb
    begin
        write.en = commit && (tlbOp == TLBWR || tlbOp == TLBFILL);
        write.index = tlbIdxIn[`TLB_INDEX_BITS-1:0];
        write.entry.e = ~tlbIdxIn[31]; // NE bit
        write.entry.g = tlbElo0In[6] & tlbElo1In[6];
        write.entry.asid = asid;
        write.entry.vppn = searchVppn;
        write.entry.lo0 = eloToPage(tlbElo0In);
        write.entry.lo1 = eloToPage(tlbElo1In);
        invalidate.en = commit && tlbOp == INVTLB;
        invalidate.op = invOp;
    end

    always_comb
    begin
        tlbIdxNext = tlbIdxIn;
        if (mmuInst && tlbOp == TLBSRCH)
        begin
            tlbIdxNext[31] = ~search.hit;
            if (search.hit)
                tlbIdxNext[`TLB_INDEX_BITS-1:0] = search.index;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || (flushW && !stallW))
            tlbIdxOut <= '0;
        else if (!stallW)
            tlbIdxOut <= tlbIdxNext;
    end

    // the array can only take one command per cycle
    assert property (@(posedge clk) disable iff (reset) !(write.en && invalidate.en));

endmodule

`default_nettype wire

// ==== source/tlbEntryArray.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mmu_consts.svh"

module tlbEntryArray (
    input wire logic clk,
    input wire logic reset,
    input wire mmuPkg::tlbWrite_t write,
    input wire mmuPkg::tlbInvalidate_t invalidate,
    input wire logic [`ASID_BITS-1:0] asid,
    input wire logic [`VPPN_BITS-1:0] searchVppn,
    input wire logic [`VADDR_BITS-1:0] lookupVaddr,
    output mmuPkg::tlbSearch_t search,
    output mmuPkg::tlbLookup_t lookup
);
    import mmuPkg::*;

    tlbEntry_t entries [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] searchHits;
    logic [`TLB_ENTRIES-1:0] lookupHits;
    logic [`TLB_INDEX_BITS-1:0] lookupIndex;
    tlbEntry_t hitEntry;

    function automatic logic invSelects(input invOp_e op, input logic g);
        case (op)
            INV_ALL, INV_ALL_ALT: return 1'b1;
            INV_GLOBAL: return g;
            INV_PRIVATE: return !g;
            default: return 1'b0;
        endcase
    endfunction

    // asid only matters for non-global entries
    function automatic logic entryMatch(input tlbEntry_t entry,
                                        input logic [`VPPN_BITS-1:0] vppn,
                                        input logic [`ASID_BITS-1:0] curAsid);
        return entry.e && (entry.vppn == vppn) && (entry.g || entry.asid == curAsid);
    endfunction

    // lowest index wins
    function automatic logic [`TLB_INDEX_BITS-1:0] lowestSet(
        input logic [`TLB_ENTRIES-1:0] hits);
        logic [`TLB_INDEX_BITS-1:0] idx;
        idx = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--)
        begin
            if (hits[i])
                idx = `TLB_INDEX_BITS'(i);
        end
        return idx;
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `TLB_ENTRIES; i++)
                entries[i].e <= 1'b0;
        end
        else
        begin
            for (int i = 0; i < `TLB_ENTRIES; i++)
            begin
                if (write.en && write.index == `TLB_INDEX_BITS'(i))
                    entries[i] <= write.entry;
                else if (invalidate.en && invSelects(invalidate.op, entries[i].g))
                    entries[i].e <= 1'b0;
            end
        end
    end

    always_comb
    begin
        for (int i = 0; i < `TLB_ENTRIES; i++)
        begin
            searchHits[i] = entryMatch(entries[i], searchVppn, asid);
            lookupHits[i] = entryMatch(entries[i],
                lookupVaddr[`VADDR_BITS-1:`PAGE_OFFSET_BITS+1], asid);
        end
    end

    assign lookupIndex = lowestSet(lookupHits);
    assign hitEntry = entries[lookupIndex];

    always_comb
    begin
        search.hit = |searchHits;
        search.index = lowestSet(searchHits);
        lookup.hit = |lookupHits;
        // bit 12 picks the odd page
        lookup.page = lookupVaddr[`PAGE_OFFSET_BITS] ? hitEntry.lo1 : hitEntry.lo0;
    end

    assert property (@(posedge clk) disable iff (reset)
        write.en |-> (int'(write.index) < `TLB_ENTRIES));

endmodule

`default_nettype wire

// ==== source/addressTranslator.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mmu_consts.svh"

module addressTranslator (
    input wire logic clk,
    input wire logic reset,
    input wire logic stall0,
    input wire logic flush0,
    input wire mmuPkg::crmd_t crmd,
    input wire mmuPkg::xlateReq_t req,
    input wire mmuPkg::tlbLookup_t lookup,
    output logic [`VADDR_BITS-1:0] lookupVaddr,
    output mmuPkg::xlateResp_t resp
);
    import mmuPkg::*;

    logic direct;
    excCode_e code;
    xlateResp_t respNext;

    assign lookupVaddr = req.vaddr;
    assign direct = crmd.da && !crmd.pg;

    // checks in priority order
    always_comb
    begin
        code = NONE;
        if (!direct)
        begin
            if (!lookup.hit)
                code = TLBR;
            else if (!lookup.page.v)
            begin
                case (req.op)
                    FETCH: code = PIF;
                    LOAD: code = PIL;
                    default: code = PIS;
                endcase
            end
            else if (crmd.plv > lookup.page.plv)
                code = PPI;
            else if (req.op == STORE && !lookup.page.d)
                code = PME; // first store to a clean page
        end
    end

    always_comb
    begin
        respNext.paddr = {lookup.page.ppn, req.vaddr[`PAGE_OFFSET_BITS-1:0]};
        respNext.memType = lookup.page.mat;
        if (direct)
        begin
            respNext.paddr = req.vaddr;
            respNext.memType = (req.op == FETCH) ? crmd.datf : crmd.datm;
        end
        respNext.paddrValid = req.valid && (code == NONE);
        respNext.excp.valid = req.valid && (code != NONE);
        respNext.excp.subcode = '0;
        respNext.excp.code = code;
    end

    always_ff @(posedge clk)
    begin
        if (reset || flush0) // flush beats stall
            resp <= '0;
        else if (!stall0)
            resp <= respNext;
    end

    assert property (@(posedge clk) disable iff (reset)
        !(resp.paddrValid && resp.excp.valid));

endmodule

`default_nettype wire

// ==== source/memoryMappingUnit.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mmu_consts.svh"

module memoryMappingUnit (
    input wire logic clk,
    input wire logic reset,
    input wire logic [3:0] instType,
    input wire mmuPkg::tlbOp_e tlbOp,
    input wire mmuPkg::invOp_e invOp,
    input wire logic [31:0] tlbIdxIn,
    input wire logic [31:0] tlbEhiIn,
    input wire logic [31:0] tlbElo0In,
    input wire logic [31:0] tlbElo1In,
    input wire logic [`ASID_BITS-1:0] asid,
    input wire mmuPkg::crmd_t crmd,
    input wire logic stallW,
    input wire logic flushW,
    input wire logic stall0,
    input wire logic flush0,
    input wire mmuPkg::xlateReq_t req,
    output logic [31:0] tlbIdxOut,
    output mmuPkg::xlateResp_t resp
);
    import mmuPkg::*;

    tlbWrite_t write;
    tlbInvalidate_t invalidate;
    tlbSearch_t search;
    tlbLookup_t lookup;
    logic [`VPPN_BITS-1:0] searchVppn;
    logic [`VADDR_BITS-1:0] lookupVaddr;

    tlbMaintenance u_tlbMaintenance (.clk, .reset, .instType, .tlbOp, .invOp, .tlbIdxIn,
        .tlbEhiIn, .tlbElo0In, .tlbElo1In, .asid, .stallW, .flushW, .search, .searchVppn,
        .write, .invalidate, .tlbIdxOut);

    tlbEntryArray u_tlbEntryArray (.clk, .reset, .write, .invalidate, .asid, .searchVppn,
        .lookupVaddr, .search, .lookup);

    addressTranslator u_addressTranslator (.clk, .reset, .stall0, .flush0, .crmd, .req,
        .lookup, .lookupVaddr, .resp);

endmodule

`default_nettype wire

// ==== verification/mmuTb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mmu_consts.svh"

module mmuTb;
    import mmuPkg::*;

    localparam int TEST_CYCLES = 60;
    localparam int WATCHDOG_NS = TEST_CYCLES * 10 + 500;
    localparam logic [18:0] VPPN_A = 19'h12345;
    localparam logic [18:0] VPPN_B = 19'h2ABCD;
    localparam logic [18:0] VPPN_C = 19'h0F00F;
    localparam logic [18:0] VPPN_D = 19'h33333;
    localparam logic [18:0] VPPN_E = 19'h44444; // never written to the array

    logic clk;
    logic reset;
    logic [3:0] instType;
    tlbOp_e tlbOp;
    invOp_e invOp;
    logic [31:0] tlbIdxIn;
    logic [31:0] tlbEhiIn;
    logic [31:0] tlbElo0In;
    logic [31:0] tlbElo1In;
    logic [`ASID_BITS-1:0] asid;
    crmd_t crmd;
    logic stallW;
    logic flushW;
    logic stall0;
    logic flush0;
    xlateReq_t req;
    logic [31:0] tlbIdxOut;
    xlateResp_t resp;
    logic [15:0] lfsrState = 16'd20;
    logic [19:0] ppnA0;
    logic [19:0] ppnA1;

    memoryMappingUnit u_memoryMappingUnit (.clk, .reset, .instType, .tlbOp, .invOp, .tlbIdxIn,
        .tlbEhiIn, .tlbElo0In, .tlbElo1In, .asid, .crmd, .stallW, .flushW, .stall0, .flush0,
        .req, .tlbIdxOut, .resp);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Testbench failed");
        $fatal(1, "timeout");
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] randBits(input int count);
        logic [31:0] bits;
        logic fb;
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [31:0] makeElo(input logic [19:0] ppn, input logic g,
        input logic [1:0] mat, input logic [1:0] plv, input logic d, input logic v);
        return {4'h0, ppn, 1'b0, g, mat, plv, d, v};
    endfunction

    task automatic checkEq(input string name, input logic [31:0] actual,
        input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic issueTlb(input tlbOp_e op, input logic [31:0] idx, input logic [31:0] ehi,
        input logic [31:0] elo0, input logic [31:0] elo1);
        instType = 4'(`INST_TYPE_MMU);
        tlbOp = op;
        tlbIdxIn = idx;
        tlbEhiIn = ehi;
        tlbElo0In = elo0;
        tlbElo1In = elo1;
        @(negedge clk);
        instType = 4'd0;
    endtask

    task automatic writeEntry(input tlbOp_e op, input logic [4:0] index,
        input logic [18:0] vppn, input logic [31:0] elo0, input logic [31:0] elo1);
        issueTlb(op, {27'd0, index}, {vppn, 13'd0}, elo0, elo1);
    endtask

    task automatic invalidateTlb(input invOp_e op);
        instType = 4'(`INST_TYPE_PRIV_MMU);
        tlbOp = INVTLB;
        invOp = op;
        @(negedge clk);
        instType = 4'd0;
    endtask

    task automatic translate(input memOp_e op, input logic [31:0] vaddr, input logic valid);
        req.valid = valid;
        req.op = op;
        req.vaddr = vaddr;
        @(negedge clk); // response registered at the rising edge in between
    endtask

    task automatic expectOk(input memOp_e op, input logic [31:0] vaddr,
        input logic [31:0] paddr, input logic [1:0] memType);
        translate(op, vaddr, 1'b1);
        checkEq("resp.paddrValid", 32'(resp.paddrValid), 32'd1);
        checkEq("resp.paddr", resp.paddr, paddr);
        checkEq("resp.memType", 32'(resp.memType), 32'(memType));
        checkEq("resp.excp", 32'(resp.excp), 32'd0);
    endtask

    task automatic expectExc(input memOp_e op, input logic [31:0] vaddr, input logic valid,
        input excCode_e code);
        translate(op, vaddr, valid);
        checkEq("resp.paddrValid", 32'(resp.paddrValid), 32'd0);
        checkEq("resp.excp.valid", 32'(resp.excp.valid), 32'(valid));
        checkEq("resp.excp.subcode", 32'(resp.excp.subcode), 32'd0);
        checkEq("resp.excp.code", 32'(resp.excp.code), 32'(code));
    endtask

    task automatic testResetAndDirect();
        logic [31:0] vaddr;
        checkEq("tlbIdxOut", tlbIdxOut, 32'd0);
        checkEq("resp.paddrValid", 32'(resp.paddrValid), 32'd0);
        checkEq("resp.excp", 32'(resp.excp), 32'd0);
        crmd = '{datm: 2'd2, datf: 2'd1, pg: 1'b0, da: 1'b1, ie: 1'b0, plv: 2'd0};
        vaddr = randBits(32);
        expectOk(FETCH, vaddr, vaddr, 2'd1);
        expectOk(LOAD, ~vaddr, ~vaddr, 2'd2);
        crmd.da = 1'b0;
        crmd.pg = 1'b1; // mapped mode from here on
    endtask

    task automatic testWriteTranslate();
        logic [11:0] off;
        ppnA0 = 20'(randBits(20));
        ppnA1 = 20'(randBits(20));
        asid = 10'h005;
        writeEntry(TLBWR, 5'd3, VPPN_A, makeElo(ppnA0, 1'b0, 2'd1, 2'd0, 1'b1, 1'b1),
            makeElo(ppnA1, 1'b0, 2'd2, 2'd0, 1'b1, 1'b1));
        off = 12'(randBits(12));
        expectOk(LOAD, {VPPN_A, 1'b0, off}, {ppnA0, off}, 2'd1);
        off = 12'(randBits(12));
        expectOk(STORE, {VPPN_A, 1'b1, off}, {ppnA1, off}, 2'd2);
        asid = 10'h006;
        expectExc(LOAD, {VPPN_A, 13'h0}, 1'b1, TLBR);
        asid = 10'h005;
        writeEntry(TLBFILL, 5'd4, VPPN_B, makeElo(20'h00B0B, 1'b1, 2'd0, 2'd0, 1'b1, 1'b1),
            makeElo(20'h00B0C, 1'b1, 2'd0, 2'd0, 1'b1, 1'b1));
        asid = 10'h006; // global entry ignores asid
        expectOk(FETCH, {VPPN_B, 13'h0AC}, {20'h00B0B, 12'h0AC}, 2'd0);
        asid = 10'h005;
    endtask

    task automatic testPageExceptions();
        expectExc(LOAD, {VPPN_C, 13'h010}, 1'b1, TLBR);
        expectExc(FETCH, {VPPN_C, 13'h010}, 1'b0, TLBR);
        writeEntry(TLBWR, 5'd5, VPPN_C, makeElo(20'h00C00, 1'b0, 2'd1, 2'd0, 1'b1, 1'b0),
            makeElo(20'h00C01, 1'b0, 2'd1, 2'd0, 1'b0, 1'b1));
        expectExc(FETCH, {VPPN_C, 13'h020}, 1'b1, PIF);
        expectExc(LOAD, {VPPN_C, 13'h020}, 1'b1, PIL);
        expectExc(STORE, {VPPN_C, 13'h020}, 1'b1, PIS);
        expectExc(STORE, {VPPN_C, 13'h1020}, 1'b1, PME); // odd half is clean
        expectOk(LOAD, {VPPN_C, 13'h1020}, {20'h00C01, 12'h020}, 2'd1);
        writeEntry(TLBWR, 5'd6, VPPN_D, makeElo(20'h00D00, 1'b0, 2'd1, 2'd0, 1'b1, 1'b1),
            makeElo(20'h00D01, 1'b0, 2'd1, 2'd0, 1'b1, 1'b1));
        crmd.plv = 2'd3;
        expectExc(LOAD, {VPPN_D, 13'h040}, 1'b1, PPI);
        crmd.plv = 2'd0;
        expectOk(LOAD, {VPPN_D, 13'h040}, {20'h00D00, 12'h040}, 2'd1);
    endtask

    task automatic testSearch();
        logic [31:0] idx;
        idx = 32'h8000_1A1F;
        issueTlb(TLBSRCH, idx, {VPPN_A, 13'd0}, 32'd0, 32'd0);
        checkEq("tlbIdxOut", tlbIdxOut, {1'b0, idx[30:5], 5'd3});
        idx = 32'h0000_2A05;
        issueTlb(TLBSRCH, idx, {VPPN_E, 13'd0}, 32'd0, 32'd0);
        checkEq("tlbIdxOut", tlbIdxOut, {1'b1, idx[30:0]});
    endtask

    task automatic testInvalidate();
        invalidateTlb(INV_GLOBAL);
        expectExc(LOAD, {VPPN_B, 13'h0}, 1'b1, TLBR);
        expectOk(LOAD, {VPPN_A, 13'h004}, {ppnA0, 12'h004}, 2'd1);
        writeEntry(TLBWR, 5'd4, VPPN_B, makeElo(20'h00B0B, 1'b1, 2'd0, 2'd0, 1'b1, 1'b1),
            makeElo(20'h00B0C, 1'b1, 2'd0, 2'd0, 1'b1, 1'b1));
        invalidateTlb(INV_PRIVATE);
        expectExc(LOAD, {VPPN_A, 13'h004}, 1'b1, TLBR);
        expectExc(LOAD, {VPPN_D, 13'h040}, 1'b1, TLBR);
        expectOk(LOAD, {VPPN_B, 13'h1008}, {20'h00B0C, 12'h008}, 2'd0);
        invalidateTlb(INV_ALL);
        expectExc(LOAD, {VPPN_B, 13'h1008}, 1'b1, TLBR);
    endtask

    task automatic testStallFlush();
        logic [31:0] vaddr;
        crmd.da = 1'b1;
        crmd.pg = 1'b0;
        vaddr = randBits(32);
        expectOk(LOAD, vaddr, vaddr, 2'd2);
        stall0 = 1'b1;
        req.vaddr = ~vaddr;
        @(negedge clk);
        checkEq("resp.paddr", resp.paddr, vaddr);
        flush0 = 1'b1;
        @(negedge clk);
        checkEq("resp.paddrValid", 32'(resp.paddrValid), 32'd0);
        checkEq("resp.paddr", resp.paddr, 32'd0);
        stall0 = 1'b0;
        flush0 = 1'b0;
        crmd.da = 1'b0;
        crmd.pg = 1'b1;
        flushW = 1'b1;
        writeEntry(TLBWR, 5'd7, VPPN_E, makeElo(20'h00E00, 1'b0, 2'd1, 2'd0, 1'b1, 1'b1),
            makeElo(20'h00E01, 1'b0, 2'd1, 2'd0, 1'b1, 1'b1));
        checkEq("tlbIdxOut", tlbIdxOut, 32'd0);
        flushW = 1'b0;
        expectExc(LOAD, {VPPN_E, 13'h0}, 1'b1, TLBR);
        stallW = 1'b1; // TLBIDX from the last cycle stays, no array write
        writeEntry(TLBWR, 5'd8, VPPN_E, makeElo(20'h00E00, 1'b0, 2'd1, 2'd0, 1'b1, 1'b1),
            makeElo(20'h00E01, 1'b0, 2'd1, 2'd0, 1'b1, 1'b1));
        checkEq("tlbIdxOut", tlbIdxOut, {27'd0, 5'd7});
        stallW = 1'b0;
        expectExc(LOAD, {VPPN_E, 13'h0}, 1'b1, TLBR);
    endtask

    initial
    begin
        reset = 1'b1;
        instType = 4'd0;
        tlbOp = TLBSRCH;
        invOp = INV_ALL;
        tlbIdxIn = '0;
        tlbEhiIn = '0;
        tlbElo0In = '0;
        tlbElo1In = '0;
        asid = '0;
        crmd = '0;
        stallW = 1'b0;
        flushW = 1'b0;
        stall0 = 1'b0;
        flush0 = 1'b0;
        req = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        testResetAndDirect();
        testWriteTranslate();
        testPageExceptions();
        testSearch();
        testInvalidate();
        testStallFlush();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/mmuPkg.sv
source/tlbMaintenance.sv
source/tlbEntryArray.sv
source/addressTranslator.sv
source/memoryMappingUnit.sv
verification/mmuTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert -f $(FILELIST) --top-module $(TOP)
TOP = mmuTb
FILELIST = src.f
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
